// ==== Makefile ====
# Verilator build and run for the RV64I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_decode_stage.sv
rv_exec_stage.sv
rv_core.sv
tb_checker.sv
tb_rv_core.sv

// ==== rv_alu.sv ====
// RV64I ALU
// Base, word and compare operations; cond carries the branch decision

`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   y,
  output logic    cond
);

  logic [5:0]  shamt;
  logic [4:0]  shamt_w;
  logic        eq, lt_s, lt_u;
  logic        is_word;
  logic [31:0] w_res;

  assign shamt   = b[5:0];
  assign shamt_w = b[4:0]; // Word shifts use 5 bits
  assign eq      = (a == b);
  assign lt_s    = ($signed(a) < $signed(b));
  assign lt_u    = (a < b);

  always_comb begin
    y       = '0;
    cond    = 1'b0;
    is_word = 1'b0;
    w_res   = '0;
    case (op)
      alu_add:      y = a + b;
      alu_sub:      y = a - b;
      alu_slt:      y = word_t'(lt_s);
      alu_sltu:     y = word_t'(lt_u);
      alu_and:      y = a & b;
      alu_or:       y = a | b;
      alu_xor:      y = a ^ b;
      alu_sll:      y = a << shamt;
      alu_srl:      y = a >> shamt;
      alu_sra:      y = $signed(a) >>> shamt;
      alu_pass_imm: y = b;
      alu_addw: begin
        is_word = 1'b1;
        w_res   = a[31:0] + b[31:0];
      end
      alu_subw: begin
        is_word = 1'b1;
        w_res   = a[31:0] - b[31:0];
      end
      alu_sllw: begin
        is_word = 1'b1;
        w_res   = a[31:0] << shamt_w;
      end
      alu_srlw: begin
        is_word = 1'b1;
        w_res   = a[31:0] >> shamt_w;
      end
      alu_sraw: begin
        is_word = 1'b1;
        w_res   = $signed(a[31:0]) >>> shamt_w;
      end
      alu_eq:   cond = eq;
      alu_ne:   cond = ~eq;
      alu_lt:   cond = lt_s;
      alu_ge:   cond = ~lt_s;
      alu_ltu:  cond = lt_u;
      alu_geu:  cond = ~lt_u;
      default:  y = '0;
    endcase
    if (is_word) y = {{32{w_res[31]}}, w_res}; // Sign-extend bit 31
    if (op inside {alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu})
      y = word_t'(cond);
  end

endmodule

// ==== rv_core.sv ====
// RV64I two-stage core
// Decode stage feeding the execute stage, retire record writes the register file

`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  inst_t   in_inst,
  input  word_t   in_pc,
  output retire_t retire
);

  decoded_t decoded;
  reg_id_t  raddr1, raddr2;
  word_t    rdata1, rdata2;

  rv_decode_stage decode_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_pc    (in_pc),
    .decoded  (decoded)
  );

  rv_exec_stage exec_i (
    .clk     (clk),
    .rst     (rst),
    .decoded (decoded),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .retire  (retire)
  );

  rv_regfile regfile_i (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (retire.valid & retire.reg_wen & (retire.rd != '0)), // Write-back from retire
    .waddr  (retire.rd),
    .wdata  (retire.result)
  );

endmodule

// ==== rv_decode_stage.sv ====
// RV64I decode stage
// Splits an instruction into fields, immediate and control flags,
// and registers the bundle with its pc

`timescale 1ns/1ps

module rv_decode_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  inst_t    in_inst,
  input  word_t    in_pc,
  output decoded_t decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  decoded_t   dec_next;

  assign opcode = in_inst[6:0];
  assign funct3 = in_inst[14:12];
  assign funct7 = in_inst[31:25];

  logic is_imm, is_imm_32, is_reg, is_32, is_lui, is_auipc, is_jal, is_jalr;
  logic is_branch, is_system, is_store;

  assign is_imm    = (opcode == op_imm);
  assign is_imm_32 = (opcode == op_imm_32);
  assign is_reg    = (opcode == op_reg);
  assign is_32     = (opcode == op_32);
  assign is_lui    = (opcode == op_lui);
  assign is_auipc  = (opcode == op_auipc);
  assign is_jal    = (opcode == op_jal);
  assign is_jalr   = (opcode == op_jalr) && (funct3 == 3'b000);
  assign is_branch = (opcode == op_branch);
  assign is_system = (opcode == op_system);
  assign is_store  = (opcode == op_store);

  logic f7_zero, f7_alt, sh6_zero, sh6_alt;

  assign f7_zero  = (funct7 == 7'b0000000);
  assign f7_alt   = (funct7 == 7'b0100000);
  assign sh6_zero = (in_inst[31:26] == 6'b000000); // RV64 shamt is 6 bits wide
  assign sh6_alt  = (in_inst[31:26] == 6'b010000);

  // Register-immediate
  logic addi, slti, sltiu, andi, ori, xori, slli, srli, srai;
  assign addi  = is_imm & (funct3 == 3'b000);
  assign slti  = is_imm & (funct3 == 3'b010);
  assign sltiu = is_imm & (funct3 == 3'b011);
  assign xori  = is_imm & (funct3 == 3'b100);
  assign ori   = is_imm & (funct3 == 3'b110);
  assign andi  = is_imm & (funct3 == 3'b111);
  assign slli  = is_imm & (funct3 == 3'b001) & sh6_zero;
  assign srli  = is_imm & (funct3 == 3'b101) & sh6_zero;
  assign srai  = is_imm & (funct3 == 3'b101) & sh6_alt;

  // Register-register, mul/div land in none of these
  logic add, sub, slt, sltu, and_inst, or_inst, xor_inst, sll, srl, sra;
  assign add      = is_reg & (funct3 == 3'b000) & f7_zero;
  assign sub      = is_reg & (funct3 == 3'b000) & f7_alt;
  assign sll      = is_reg & (funct3 == 3'b001) & f7_zero;
  assign slt      = is_reg & (funct3 == 3'b010) & f7_zero;
  assign sltu     = is_reg & (funct3 == 3'b011) & f7_zero;
  assign xor_inst = is_reg & (funct3 == 3'b100) & f7_zero;
  assign srl      = is_reg & (funct3 == 3'b101) & f7_zero;
  assign sra      = is_reg & (funct3 == 3'b101) & f7_alt;
  assign or_inst  = is_reg & (funct3 == 3'b110) & f7_zero;
  assign and_inst = is_reg & (funct3 == 3'b111) & f7_zero;

  // Word forms
  logic addiw, slliw, srliw, sraiw, addw, subw, sllw, srlw, sraw;
  assign addiw = is_imm_32 & (funct3 == 3'b000);
  assign slliw = is_imm_32 & (funct3 == 3'b001) & f7_zero;
  assign srliw = is_imm_32 & (funct3 == 3'b101) & f7_zero;
  assign sraiw = is_imm_32 & (funct3 == 3'b101) & f7_alt;
  assign addw  = is_32 & (funct3 == 3'b000) & f7_zero;
  assign subw  = is_32 & (funct3 == 3'b000) & f7_alt;
  assign sllw  = is_32 & (funct3 == 3'b001) & f7_zero;
  assign srlw  = is_32 & (funct3 == 3'b101) & f7_zero;
  assign sraw  = is_32 & (funct3 == 3'b101) & f7_alt;

  // Branches and system
  logic beq, bne, blt, bge, bltu, bgeu, ebreak, legal;
  assign beq    = is_branch & (funct3 == 3'b000);
  assign bne    = is_branch & (funct3 == 3'b001);
  assign blt    = is_branch & (funct3 == 3'b100);
  assign bge    = is_branch & (funct3 == 3'b101);
  assign bltu   = is_branch & (funct3 == 3'b110);
  assign bgeu   = is_branch & (funct3 == 3'b111);
  assign ebreak = is_system & (funct3 == 3'b000) & (in_inst[31:20] == 12'h001);

  assign legal = addi | slti | sltiu | andi | ori | xori | slli | srli | srai |
                 add | sub | slt | sltu | and_inst | or_inst | xor_inst |
                 sll | srl | sra | addiw | slliw | srliw | sraiw |
                 addw | subw | sllw | srlw | sraw | is_lui | is_auipc |
                 is_jal | is_jalr | beq | bne | blt | bge | bltu | bgeu | ebreak;

  always_comb begin
    dec_next          = '0;
    dec_next.valid    = in_valid;
    dec_next.pc       = in_pc;
    dec_next.rd       = in_inst[11:7];
    dec_next.rs1      = in_inst[19:15];
    dec_next.rs2      = in_inst[24:20];

    // Immediate by format
    if (is_lui | is_auipc)
      dec_next.imm = {{32{in_inst[31]}}, in_inst[31:12], 12'b0};
    else if (is_jal)
      dec_next.imm = {{43{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                      in_inst[30:21], 1'b0};
    else if (is_branch)
      dec_next.imm = {{51{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                      in_inst[11:8], 1'b0};
    else if (is_store)
      dec_next.imm = {{52{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
    else
      dec_next.imm = {{52{in_inst[31]}}, in_inst[31:20]}; // I-type default

    dec_next.alu_op = alu_add; // addi, add, jalr address
    if (sub)                  dec_next.alu_op = alu_sub;
    else if (slti | slt)      dec_next.alu_op = alu_slt;
    else if (sltiu | sltu)    dec_next.alu_op = alu_sltu;
    else if (andi | and_inst) dec_next.alu_op = alu_and;
    else if (ori | or_inst)   dec_next.alu_op = alu_or;
    else if (xori | xor_inst) dec_next.alu_op = alu_xor;
    else if (slli | sll)      dec_next.alu_op = alu_sll;
    else if (srli | srl)      dec_next.alu_op = alu_srl;
    else if (srai | sra)      dec_next.alu_op = alu_sra;
    else if (is_lui)          dec_next.alu_op = alu_pass_imm;
    else if (addiw | addw)    dec_next.alu_op = alu_addw;
    else if (subw)            dec_next.alu_op = alu_subw;
    else if (slliw | sllw)    dec_next.alu_op = alu_sllw;
    else if (srliw | srlw)    dec_next.alu_op = alu_srlw;
    else if (sraiw | sraw)    dec_next.alu_op = alu_sraw;
    else if (beq)             dec_next.alu_op = alu_eq;
    else if (bne)             dec_next.alu_op = alu_ne;
    else if (blt)             dec_next.alu_op = alu_lt;
    else if (bge)             dec_next.alu_op = alu_ge;
    else if (bltu)            dec_next.alu_op = alu_ltu;
    else if (bgeu)            dec_next.alu_op = alu_geu;

    dec_next.need_imm     = is_imm | is_imm_32 | is_lui | is_auipc | is_jal | is_jalr;
    dec_next.reg_wen      = is_imm | is_imm_32 | is_reg | is_32 | is_lui | is_auipc |
                            is_jal | is_jalr;
    dec_next.is_auipc     = is_auipc;
    dec_next.is_jal       = is_jal;
    dec_next.is_jalr      = is_jalr;
    dec_next.is_branch    = is_branch;
    dec_next.is_ebreak    = ebreak;
    dec_next.inst_not_ipl = ~legal;
  end

  always_ff @(posedge clk) begin
    decoded <= dec_next;
    if (rst) decoded.valid <= 1'b0; // Payload fields keep running
  end

endmodule

// ==== rv_exec_stage.sv ====
// RV64I execute stage
// Operand fetch with forwarding, ALU, branch/jump resolution and retire record

`timescale 1ns/1ps

module rv_exec_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  decoded_t decoded,
  output reg_id_t  raddr1,
  output reg_id_t  raddr2,
  input  word_t    rdata1,
  input  word_t    rdata2,
  output retire_t  retire
);

  logic    fwd1, fwd2, alu_cond, trap;
  word_t   op_a, op_b_reg, op_b, alu_y;
  word_t   pc_plus_4, pc_plus_imm;
  retire_t ret_next;

  assign raddr1 = decoded.rs1;
  assign raddr2 = decoded.rs2;

  // Only the record one ahead can be missing from the register file
  assign fwd1 = retire.valid & retire.reg_wen & (retire.rd != '0) & (retire.rd == decoded.rs1);
  assign fwd2 = retire.valid & retire.reg_wen & (retire.rd != '0) & (retire.rd == decoded.rs2);

  assign op_a     = fwd1 ? retire.result : rdata1;
  assign op_b_reg = fwd2 ? retire.result : rdata2;
  assign op_b     = decoded.need_imm ? decoded.imm : op_b_reg;

  rv_alu alu_i (
    .op   (decoded.alu_op),
    .a    (op_a),
    .b    (op_b),
    .y    (alu_y),
    .cond (alu_cond)
  );

  assign pc_plus_4   = decoded.pc + word_t'(4);
  assign pc_plus_imm = decoded.pc + decoded.imm;
  assign trap        = decoded.is_ebreak | decoded.inst_not_ipl;

  always_comb begin
    ret_next         = '0;
    ret_next.valid   = decoded.valid;
    ret_next.pc      = decoded.pc;
    ret_next.rd      = decoded.rd;
    ret_next.result  = alu_y;
    ret_next.next_pc = pc_plus_4;
    if (decoded.is_jal | decoded.is_jalr) ret_next.result = pc_plus_4;  // Link value
    if (decoded.is_auipc)                 ret_next.result = pc_plus_imm;
    if (decoded.is_jal)                   ret_next.next_pc = pc_plus_imm;
    if (decoded.is_jalr)                  ret_next.next_pc = {alu_y[xlen-1:1], 1'b0};
    if (decoded.is_branch && alu_cond)    ret_next.next_pc = pc_plus_imm;
    if (trap)                             ret_next.next_pc = decoded.pc; // Stay put
    ret_next.reg_wen = decoded.reg_wen & ~trap;
    ret_next.trap    = trap;
  end

  always_ff @(posedge clk) begin
    retire <= ret_next;
    if (rst) retire.valid <= 1'b0;
  end

endmodule

// ==== rv_pkg.sv ====
// RV64I pipeline shared definitions
// Widths, opcode constants, ALU operation codes and the stage records

package rv_pkg;

  localparam int xlen         = 64;
  localparam int reg_id_width = 5;

  typedef logic [31:0]             inst_t;
  typedef logic [xlen-1:0]         word_t;   // pc, imm, operands, results
  typedef logic [reg_id_width-1:0] reg_id_t;

  // Major opcodes, inst[6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_32     = 7'b0111011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] op_store  = 7'b0100011; // Only for S-immediate selection

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_imm,
    alu_addw,
    alu_subw,
    alu_sllw,
    alu_srlw,
    alu_sraw,
    alu_eq,   // Compare group drives cond
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  typedef struct packed {
    logic    valid;
    word_t   pc;
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    word_t   imm;
    alu_op_e alu_op;
    logic    need_imm;     // Operand b from imm, not rs2
    logic    reg_wen;
    logic    is_auipc;
    logic    is_jal;
    logic    is_jalr;
    logic    is_branch;
    logic    is_ebreak;
    logic    inst_not_ipl; // Encoding outside the supported set
  } decoded_t;

  typedef struct packed {
    logic    valid;
    word_t   pc;
    reg_id_t rd;
    word_t   result;
    logic    reg_wen;
    word_t   next_pc;
    logic    trap;
  } retire_t;

endpackage

// ==== rv_regfile.sv ====
// Integer register file
// 32 x 64-bit, two asynchronous read ports, one write port, x0 reads zero

`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  reg_id_t raddr1,
  input  reg_id_t raddr2,
  output word_t   rdata1,
  output word_t   rdata2,
  input  logic    wen,
  input  reg_id_t waddr,
  input  word_t   wdata
);

  word_t regs [2**reg_id_width];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_id_width; i++) regs[i] <= '0;
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== tb_checker.sv ====
// Retire checker for the RV64I core testbench
// Compares each retire record with the expected table and checks the 2-cycle latency

`timescale 1ns/1ps

module tb_checker import rv_pkg::*; #(parameter int n_tests = 1) (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  retire_t retire,
  input  retire_t exp_tab [n_tests],
  output int      n_checked,
  output int      n_errors
);

  int cyc;                    // Rising edges seen so far
  int n_strobes;
  int strobe_cyc [n_tests];   // Edge at which each input was taken

  always @(posedge clk) begin
    if (!rst && in_valid && n_strobes < n_tests) begin
      strobe_cyc[n_strobes] = cyc;
      n_strobes++;
    end
    cyc++;
  end

  function automatic int field_mismatch(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("ERR %0t: test %0d %s is %h, expected %h", $time, n_checked, name, got, want);
      return 1;
    end
    return 0;
  endfunction

  task automatic check_retire();
    retire_t want;
    int      bad;
    bad = 0;
    if (n_checked >= n_tests) begin
      $display("ERR %0t: unexpected retire for pc %h", $time, retire.pc);
      n_errors++;
    end else begin
      want = exp_tab[n_checked];
      bad += field_mismatch("pc", retire.pc, want.pc);
      bad += field_mismatch("next_pc", retire.next_pc, want.next_pc);
      bad += field_mismatch("trap", word_t'(retire.trap), word_t'(want.trap));
      bad += field_mismatch("reg_wen", word_t'(retire.reg_wen), word_t'(want.reg_wen));
      if (want.reg_wen) begin   // rd and result carry no meaning without a write
        bad += field_mismatch("rd", word_t'(retire.rd), word_t'(want.rd));
        bad += field_mismatch("result", retire.result, want.result);
      end
      if (n_checked >= n_strobes || cyc - strobe_cyc[n_checked] != 2) begin
        $display("ERR %0t: test %0d retired off the 2-cycle latency", $time, n_checked);
        bad++;
      end
      if (bad == 0)
        $display("test %0d ok: pc %h result %h next_pc %h", n_checked, retire.pc,
                 retire.result, retire.next_pc);
      else
        n_errors++;
      n_checked++;
    end
  endtask

  // Retire record is stable between rising edges
  always @(negedge clk) begin
    if (!rst && retire.valid) check_retire();
  end

endmodule

// ==== tb_rv_core.sv ====
// Testbench for the RV64I core
// Drives a table of instructions with random idle gaps and checks every retire record

`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  localparam int n_tests = 54;
  localparam int period  = 20;

  logic        clk;
  logic        rst;
  logic        in_valid;
  inst_t       in_inst;
  word_t       in_pc;
  retire_t     retire;
  logic [15:0] lfsr;
  int          n_rows;
  int          n_checked;
  int          n_errors;

  inst_t   inst_tab  [n_tests];
  logic    chain_tab [n_tests];   // Set when the entry follows its predecessor directly
  retire_t exp_tab   [n_tests];

  rv_core dut_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_pc    (in_pc),
    .retire   (retire)
  );

  tb_checker #(.n_tests(n_tests)) chk_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .retire    (retire),
    .exp_tab   (exp_tab),
    .n_checked (n_checked),
    .n_errors  (n_errors)
  );

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic inst_t i_type(input logic [6:0] op, input int f3, input int rd,
                                   input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic inst_t r_type(input logic [6:0] op, input int f3, input int f7,
                                   input int rd, input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic inst_t u_type(input logic [6:0] op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic inst_t j_type(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
  endfunction

  function automatic inst_t b_type(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t row_pc(input int idx);
    return 64'h1000 + word_t'(4 * idx);
  endfunction

  task automatic ctl_entry(input inst_t inst, input int rd, input word_t result, input int wen,
                           input word_t next_pc, input int trap, input int chain);
    inst_tab[n_rows]         = inst;
    chain_tab[n_rows]        = (chain != 0);
    exp_tab[n_rows]          = '0;
    exp_tab[n_rows].valid    = 1'b1;
    exp_tab[n_rows].pc       = row_pc(n_rows);
    exp_tab[n_rows].rd       = reg_id_t'(rd);
    exp_tab[n_rows].result   = result;
    exp_tab[n_rows].reg_wen  = (wen != 0);
    exp_tab[n_rows].next_pc  = next_pc;
    exp_tab[n_rows].trap     = (trap != 0);
    n_rows++;
  endtask

  // Plain instruction falling through to pc+4
  task automatic alu_entry(input inst_t inst, input int rd, input word_t result,
                           input int chain);
    ctl_entry(inst, rd, result, 1, row_pc(n_rows) + 64'd4, 0, chain);
  endtask

  task automatic fill_table();
    // Register-immediate group seeds x1 = 100 and x2 = -5 for everything below
    alu_entry(i_type(op_imm, 0, 1, 0, 100), 1, 64'h64, 0);
    alu_entry(i_type(op_imm, 0, 2, 0, -5), 2, 64'hffff_ffff_ffff_fffb, 0);
    alu_entry(i_type(op_imm, 2, 3, 2, 1), 3, 64'h1, 0);
    alu_entry(i_type(op_imm, 3, 4, 2, 1), 4, 64'h0, 0);
    alu_entry(i_type(op_imm, 7, 5, 1, 15), 5, 64'h4, 0);
    alu_entry(i_type(op_imm, 6, 6, 1, -256), 6, 64'hffff_ffff_ffff_ff64, 0);
    alu_entry(i_type(op_imm, 4, 7, 2, -1), 7, 64'h4, 0);
    alu_entry(i_type(op_imm, 1, 8, 1, 40), 8, 64'h0000_6400_0000_0000, 0);
    alu_entry(i_type(op_imm, 5, 9, 2, 60), 9, 64'hf, 0);
    alu_entry(i_type(op_imm, 5, 10, 2, 'h401), 10, 64'hffff_ffff_ffff_fffd, 0);
    // Dependent register-register chain with no idle cycles
    alu_entry(r_type(op_reg, 0, 0, 11, 1, 2), 11, 64'h5f, 0);
    alu_entry(r_type(op_reg, 0, 'h20, 12, 11, 1), 12, 64'hffff_ffff_ffff_fffb, 1);
    alu_entry(r_type(op_reg, 2, 0, 13, 12, 11), 13, 64'h1, 1);
    alu_entry(r_type(op_reg, 3, 0, 14, 12, 13), 14, 64'h0, 1);
    alu_entry(r_type(op_reg, 7, 0, 15, 12, 1), 15, 64'h60, 1);
    alu_entry(r_type(op_reg, 6, 0, 16, 4, 15), 16, 64'h60, 1);
    alu_entry(r_type(op_reg, 4, 0, 17, 16, 2), 17, 64'hffff_ffff_ffff_ff9b, 1);
    alu_entry(r_type(op_reg, 1, 0, 18, 17, 3), 18, 64'hffff_ffff_ffff_ff36, 1);
    alu_entry(r_type(op_reg, 5, 0, 19, 18, 5), 19, 64'h0fff_ffff_ffff_fff3, 1);
    alu_entry(r_type(op_reg, 5, 'h20, 20, 18, 5), 20, 64'hffff_ffff_ffff_fff3, 1);
    // Word forms
    alu_entry(i_type(op_imm_32, 0, 21, 1, -101), 21, 64'hffff_ffff_ffff_ffff, 0);
    alu_entry(r_type(op_32, 0, 0, 22, 8, 2), 22, 64'hffff_ffff_ffff_fffb, 0);
    alu_entry(r_type(op_32, 0, 'h20, 23, 4, 1), 23, 64'hffff_ffff_ffff_ff9c, 0);
    alu_entry(i_type(op_imm_32, 1, 24, 1, 25), 24, 64'hffff_ffff_c800_0000, 0);
    alu_entry(i_type(op_imm_32, 5, 25, 2, 4), 25, 64'h0000_0000_0fff_ffff, 0);
    alu_entry(i_type(op_imm_32, 5, 26, 2, 'h404), 26, 64'hffff_ffff_ffff_ffff, 0);
    alu_entry(r_type(op_32, 1, 0, 27, 24, 5), 27, 64'hffff_ffff_8000_0000, 0);
    alu_entry(r_type(op_32, 5, 0, 28, 24, 5), 28, 64'h0000_0000_0c80_0000, 0);
    alu_entry(r_type(op_32, 5, 'h20, 29, 24, 5), 29, 64'hffff_ffff_fc80_0000, 0);
    // lui, auipc, jumps
    alu_entry(u_type(op_lui, 30, 'h80001), 30, 64'hffff_ffff_8000_1000, 0);
    ctl_entry(i_type(op_jalr, 0, 31, 30, 5), 31, 64'h107c, 1, 64'hffff_ffff_8000_1004, 0, 1);
    alu_entry(u_type(op_auipc, 31, 'h1), 31, 64'h207c, 0);
    alu_entry(u_type(op_auipc, 30, 'hfffff), 30, 64'h80, 0);
    ctl_entry(j_type(31, 'h100), 31, 64'h1088, 1, 64'h1184, 0, 0);
    ctl_entry(j_type(30, -'h20), 30, 64'h108c, 1, 64'h1068, 0, 0);
    ctl_entry(i_type(op_jalr, 0, 29, 1, 3), 29, 64'h1090, 1, 64'h66, 0, 0);
    // Each branch taken then not taken
    ctl_entry(b_type(0, 1, 1, 16), 0, '0, 0, 64'h10a0, 0, 0);
    ctl_entry(b_type(0, 1, 2, 16), 0, '0, 0, 64'h1098, 0, 0);
    ctl_entry(b_type(1, 1, 2, -8), 0, '0, 0, 64'h1090, 0, 0);
    ctl_entry(b_type(1, 1, 1, -8), 0, '0, 0, 64'h10a0, 0, 0);
    ctl_entry(b_type(4, 2, 1, 32), 0, '0, 0, 64'h10c0, 0, 0);
    ctl_entry(b_type(4, 1, 2, 32), 0, '0, 0, 64'h10a8, 0, 0);
    ctl_entry(b_type(5, 1, 2, -16), 0, '0, 0, 64'h1098, 0, 0);
    ctl_entry(b_type(5, 2, 1, -16), 0, '0, 0, 64'h10b0, 0, 0);
    ctl_entry(b_type(6, 1, 2, 12), 0, '0, 0, 64'h10bc, 0, 0);
    ctl_entry(b_type(6, 2, 1, 12), 0, '0, 0, 64'h10b8, 0, 0);
    ctl_entry(b_type(7, 2, 1, 64), 0, '0, 0, 64'h10f8, 0, 0);
    ctl_entry(b_type(7, 1, 2, 64), 0, '0, 0, 64'h10c0, 0, 0);
    // Traps from ebreak, ld, sd and mul
    ctl_entry(32'h0010_0073, 0, '0, 0, 64'h10c0, 1, 0);
    ctl_entry(i_type(7'b0000011, 3, 5, 1, 0), 0, '0, 0, 64'h10c4, 1, 0);
    ctl_entry(32'h0020_b423, 0, '0, 0, 64'h10c8, 1, 0);
    ctl_entry(r_type(op_reg, 0, 1, 6, 1, 2), 0, '0, 0, 64'h10cc, 1, 0);
    // x0 write is dropped and x5 survives the trapped load
    alu_entry(i_type(op_imm, 0, 0, 1, 7), 0, 64'h6b, 0);
    alu_entry(r_type(op_reg, 0, 0, 31, 0, 5), 31, 64'h4, 1);
  endtask

  initial begin
    logic [1:0] gap;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_inst  = '0;
    in_pc    = '0;
    lfsr     = 16'd72;
    fill_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      if (!chain_tab[i]) begin
        lfsr   = lfsr_next(lfsr);   // One step per bit
        gap[0] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        gap[1] = lfsr[0];
        repeat (gap) @(negedge clk);
      end
      in_valid = 1'b1;
      in_inst  = inst_tab[i];
      in_pc    = exp_tab[i].pc;
      @(negedge clk);
      in_valid = 1'b0;
    end
    wait (n_checked == n_tests);
    repeat (4) @(negedge clk);   // Room for a stray retire
    $display("Checked %0d of %0d tests, %0d failed", n_checked, n_tests, n_errors);
    if (n_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Worst case is well under 6 cycles per entry plus reset
  initial begin
    #(period * (n_tests * 6 + 20));
    $display("Watchdog expired with only %0d of %0d instructions retired", n_checked, n_tests);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
